//--- common/mmu_settings.svh
// SV39 data MMU settings
`ifndef MMU_SETTINGS_SVH
`define MMU_SETTINGS_SVH

// ------------------------------
// address and page number widths
// ------------------------------
`define MMU_VLEN        39
`define MMU_XLEN        64
`define MMU_PPNW        44
`define MMU_PLEN        56
`define MMU_VPNW        27
`define MMU_TLB_ENTRIES 4

// flag byte of a leaf PTE, G sits at bit 5 and is not used here
`define MMU_PTE_V 0
`define MMU_PTE_R 1
`define MMU_PTE_W 2
`define MMU_PTE_X 3
`define MMU_PTE_U 4
`define MMU_PTE_A 6
`define MMU_PTE_D 7

// privilege levels
`define MMU_PRIV_U 2'd0
`define MMU_PRIV_S 2'd1

// page sizes held per TLB entry
`define MMU_PAGE_4K 2'd0
`define MMU_PAGE_2M 2'd1
`define MMU_PAGE_1G 2'd2

// exception causes
`define MMU_CAUSE_LD_ACCESS 6'd5
`define MMU_CAUSE_ST_ACCESS 6'd7
`define MMU_CAUSE_LD_PAGE   6'd13
`define MMU_CAUSE_ST_PAGE   6'd15

`endif

//--- common/mmu_pkg.sv
// SV39 data MMU types
`default_nettype none
`include "mmu_settings.svh"

package mmu_pkg;

    // sv39 virtual address, read either as one word or split
    // into the three VPN levels and the page offset
    typedef struct packed {
        logic [8:0]  vpn2;
        logic [8:0]  vpn1;
        logic [8:0]  vpn0;
        logic [11:0] offset;
    } sv39_vaddr_fields_t;

    typedef union packed {
        logic [`MMU_VLEN-1:0] flat;
        sv39_vaddr_fields_t   f;
    } sv39_vaddr_u;

endpackage

`default_nettype wire

//--- dtlb/dtlb.sv
// Data TLB
`default_nettype none
`include "mmu_settings.svh"

module dtlb import mmu_pkg::*; (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    input  wire logic                 flush_i,
    input  wire logic                 refill_i,
    input  wire logic [`MMU_VPNW-1:0] refill_vpn_i,
    input  wire logic [`MMU_PPNW-1:0] refill_ppn_i,
    input  wire logic [7:0]           refill_flags_i,
    input  wire logic [1:0]           refill_size_i,
    input  wire sv39_vaddr_u          lu_vaddr_i,
    output logic                      lu_hit_o,
    output logic [`MMU_PPNW-1:0]      lu_ppn_o,
    output logic [7:0]                lu_flags_o,
    output logic [1:0]                lu_size_o
);

    localparam int unsigned N  = `MMU_TLB_ENTRIES;
    localparam int unsigned IW = $clog2(`MMU_TLB_ENTRIES);

    logic [N-1:0]         valid_q;
    logic [`MMU_VPNW-1:0] vpn_q   [N];
    logic [`MMU_PPNW-1:0] ppn_q   [N];
    logic [7:0]           flags_q [N];
    logic [1:0]           size_q  [N];
    logic [IW-1:0]        rr_ptr_q;

    logic [`MMU_VPNW-1:0] lu_vpn;
    logic [N-1:0]         lu_match;
    logic [N-1:0]         rf_match;
    logic                 rf_any;
    logic [IW-1:0]        rf_idx;

    // compare a VPN against a tag at the granularity of the entry's page size
    function automatic logic tag_match(input logic [`MMU_VPNW-1:0] vpn,
                                       input logic [`MMU_VPNW-1:0] tag,
                                       input logic [1:0]           size);
        logic hi_ok;
        logic mid_ok;
        logic lo_ok;
        hi_ok  = (vpn[26:18] == tag[26:18]);
        mid_ok = (size == `MMU_PAGE_1G) || (vpn[17:9] == tag[17:9]);
        lo_ok  = (size != `MMU_PAGE_4K) || (vpn[8:0] == tag[8:0]);
        return hi_ok && mid_ok && lo_ok;
    endfunction

    assign lu_vpn = {lu_vaddr_i.f.vpn2, lu_vaddr_i.f.vpn1, lu_vaddr_i.f.vpn0};

    always_comb begin
        for (int i = 0; i < N; i++) begin
            lu_match[i] = valid_q[i] && tag_match(lu_vpn, vpn_q[i], size_q[i]);
            rf_match[i] = valid_q[i] && tag_match(refill_vpn_i, vpn_q[i], size_q[i]);
        end
    end

    // ------------------------------
    // lookup
    // ------------------------------
    assign lu_hit_o = |lu_match;

    always_comb begin
        lu_ppn_o   = '0;
        lu_flags_o = '0;
        lu_size_o  = '0;
        for (int i = 0; i < N; i++) begin
            if (lu_match[i]) begin
                lu_ppn_o   = ppn_q[i];
                lu_flags_o = flags_q[i];
                lu_size_o  = size_q[i];
            end
        end
    end

    // ------------------------------
    // refill and flush
    // ------------------------------
    // an entry already covering the refill VPN is reused, lowest index first
    always_comb begin
        rf_any = 1'b0;
        rf_idx = rr_ptr_q;
        for (int i = N - 1; i >= 0; i--) begin
            if (rf_match[i]) begin
                rf_any = 1'b1;
                rf_idx = IW'(i);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            rr_ptr_q <= '0;
        end else if (flush_i) begin
            // flush wins over a refill in the same cycle, victim restarts at 0
            valid_q  <= '0;
            rr_ptr_q <= '0;
        end else if (refill_i) begin
            valid_q[rf_idx] <= 1'b1;
            if (!rf_any) begin
                rr_ptr_q <= (rr_ptr_q == IW'(N - 1)) ? '0 : rr_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (refill_i) begin
            vpn_q[rf_idx]   <= refill_vpn_i;
            ppn_q[rf_idx]   <= refill_ppn_i;
            flags_q[rf_idx] <= refill_flags_i;
            size_q[rf_idx]  <= refill_size_i;
        end
    end

    // replacement must never leave two entries covering the same address
    a_single_hit: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(lu_match))
        else $error("dtlb: more than one entry hits");

endmodule

`default_nettype wire

//--- design/perm_check.sv
// Page permission check
`default_nettype none
`include "mmu_settings.svh"

module perm_check (
    input  wire logic [`MMU_XLEN-1:0] vaddr_i,
    input  wire logic                 is_store_i,
    input  wire logic [1:0]           priv_i,
    input  wire logic                 sum_i,
    input  wire logic                 hit_i,
    input  wire logic [7:0]           flags_i,
    output logic                      ex_valid_o,
    output logic [5:0]                ex_cause_o
);

    logic canonical;
    logic user_fault;
    logic sum_fault;
    logic write_fault;
    logic page_fault;

    // ------------------------------
    // canonical address
    // ------------------------------
    // bits 63 down to 38 must all carry the same value
    assign canonical = (&vaddr_i[`MMU_XLEN-1:`MMU_VLEN-1])
                    || !(|vaddr_i[`MMU_XLEN-1:`MMU_VLEN-1]);

    // ------------------------------
    // page permissions
    // ------------------------------
    // user mode may only touch user pages
    assign user_fault = (priv_i == `MMU_PRIV_U) && !flags_i[`MMU_PTE_U];

    // supervisor reaches user pages only with SUM set
    assign sum_fault = (priv_i == `MMU_PRIV_S) && flags_i[`MMU_PTE_U] && !sum_i;

    // stores need a writable page that is already dirty
    assign write_fault = is_store_i && (!flags_i[`MMU_PTE_W] || !flags_i[`MMU_PTE_D]);

    // only a hit carries meaningful flags
    assign page_fault = hit_i && (user_fault || sum_fault || write_fault);

    always_comb begin
        ex_valid_o = 1'b0;
        ex_cause_o = '0;
        if (!canonical) begin
            ex_valid_o = 1'b1;
            ex_cause_o = is_store_i ? `MMU_CAUSE_ST_ACCESS : `MMU_CAUSE_LD_ACCESS;
        end else if (page_fault) begin
            ex_valid_o = 1'b1;
            ex_cause_o = is_store_i ? `MMU_CAUSE_ST_PAGE : `MMU_CAUSE_LD_PAGE;
        end
    end

endmodule

`default_nettype wire

//--- design/xlate_result.sv
// Translation result stage
`default_nettype none
`include "mmu_settings.svh"

module xlate_result import mmu_pkg::*; (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    input  wire logic                 req_i,
    input  wire logic                 en_translation_i,
    input  wire logic [`MMU_XLEN-1:0] vaddr_i,
    input  wire logic                 hit_i,
    input  wire logic [`MMU_PPNW-1:0] ppn_i,
    input  wire logic [1:0]           size_i,
    input  wire logic                 chk_ex_valid_i,
    input  wire logic [5:0]           chk_cause_i,
    output logic                      hit_o,
    output logic                      valid_o,
    output logic                      miss_o,
    output logic [`MMU_PLEN-1:0]      paddr_o,
    output logic                      ex_valid_o,
    output logic [5:0]                ex_cause_o,
    output logic [`MMU_XLEN-1:0]      ex_tval_o
);

    logic                 req_q;
    logic                 en_q;
    logic [`MMU_XLEN-1:0] vaddr_q;
    logic                 hit_q;
    logic [`MMU_PPNW-1:0] ppn_q;
    logic [1:0]           size_q;
    logic                 chk_ex_q;
    logic [5:0]           cause_q;

    sv39_vaddr_u          va_q;
    logic [`MMU_PPNW-1:0] ppn_sel;

    // without translation every request counts as a hit
    assign hit_o = en_translation_i ? hit_i : 1'b1;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q <= 1'b0;
        end else begin
            req_q <= req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            en_q     <= en_translation_i;
            vaddr_q  <= vaddr_i;
            hit_q    <= hit_i;
            ppn_q    <= ppn_i;
            size_q   <= size_i;
            chk_ex_q <= chk_ex_valid_i;
            cause_q  <= chk_cause_i;
        end
    end

    // ------------------------------
    // result formatting
    // ------------------------------
    assign va_q = vaddr_q[`MMU_VLEN-1:0];

    // superpages take the low VPN levels from the virtual address
    always_comb begin
        ppn_sel = ppn_q;
        if (size_q == `MMU_PAGE_2M) begin
            ppn_sel[8:0] = va_q.f.vpn0;
        end else if (size_q == `MMU_PAGE_1G) begin
            ppn_sel[17:0] = {va_q.f.vpn1, va_q.f.vpn0};
        end
    end

    always_comb begin
        if (!en_q) begin
            paddr_o = vaddr_q[`MMU_PLEN-1:0];
        end else if (hit_q && !chk_ex_q) begin
            paddr_o = {ppn_sel, va_q.f.offset};
        end else begin
            paddr_o = '0;
        end
    end

    assign valid_o    = req_q;
    assign ex_valid_o = req_q && en_q && chk_ex_q;
    assign miss_o     = req_q && en_q && !hit_q && !chk_ex_q;
    assign ex_cause_o = ex_valid_o ? cause_q : '0;
    assign ex_tval_o  = ex_valid_o ? vaddr_q : '0;

    // a raised exception always carries one of the four data-side causes
    a_known_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ex_valid_o |-> (ex_cause_o inside {`MMU_CAUSE_LD_ACCESS, `MMU_CAUSE_ST_ACCESS,
                                           `MMU_CAUSE_LD_PAGE, `MMU_CAUSE_ST_PAGE}))
        else $error("xlate_result: exception with an unknown cause");

endmodule

`default_nettype wire

//--- design/mmu_data_top.sv
// SV39 data MMU top
`default_nettype none
`include "mmu_settings.svh"

module mmu_data_top import mmu_pkg::*; (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    // load/store request
    input  wire logic                 req_i,
    input  wire logic [`MMU_XLEN-1:0] vaddr_i,
    input  wire logic                 is_store_i,
    input  wire logic [1:0]           priv_i,
    input  wire logic                 sum_i,
    input  wire logic                 en_translation_i,
    // TLB maintenance
    input  wire logic                 refill_i,
    input  wire logic [`MMU_VPNW-1:0] refill_vpn_i,
    input  wire logic [`MMU_PPNW-1:0] refill_ppn_i,
    input  wire logic [7:0]           refill_flags_i,
    input  wire logic [1:0]           refill_size_i,
    input  wire logic                 flush_i,
    // results
    output logic                      hit_o,
    output logic                      valid_o,
    output logic                      miss_o,
    output logic [`MMU_PLEN-1:0]      paddr_o,
    output logic                      ex_valid_o,
    output logic [5:0]                ex_cause_o,
    output logic [`MMU_XLEN-1:0]      ex_tval_o
);

    sv39_vaddr_u          lu_vaddr;
    logic                 lu_hit;
    logic [`MMU_PPNW-1:0] lu_ppn;
    logic [7:0]           lu_flags;
    logic [1:0]           lu_size;
    logic                 chk_ex_valid;
    logic [5:0]           chk_cause;

    assign lu_vaddr = vaddr_i[`MMU_VLEN-1:0];

    dtlb u_dtlb (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_i),
        .refill_i       (refill_i),
        .refill_vpn_i   (refill_vpn_i),
        .refill_ppn_i   (refill_ppn_i),
        .refill_flags_i (refill_flags_i),
        .refill_size_i  (refill_size_i),
        .lu_vaddr_i     (lu_vaddr),
        .lu_hit_o       (lu_hit),
        .lu_ppn_o       (lu_ppn),
        .lu_flags_o     (lu_flags),
        .lu_size_o      (lu_size)
    );

    perm_check u_perm_check (
        .vaddr_i    (vaddr_i),
        .is_store_i (is_store_i),
        .priv_i     (priv_i),
        .sum_i      (sum_i),
        .hit_i      (lu_hit),
        .flags_i    (lu_flags),
        .ex_valid_o (chk_ex_valid),
        .ex_cause_o (chk_cause)
    );

    xlate_result u_xlate_result (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .req_i            (req_i),
        .en_translation_i (en_translation_i),
        .vaddr_i          (vaddr_i),
        .hit_i            (lu_hit),
        .ppn_i            (lu_ppn),
        .size_i           (lu_size),
        .chk_ex_valid_i   (chk_ex_valid),
        .chk_cause_i      (chk_cause),
        .hit_o            (hit_o),
        .valid_o          (valid_o),
        .miss_o           (miss_o),
        .paddr_o          (paddr_o),
        .ex_valid_o       (ex_valid_o),
        .ex_cause_o       (ex_cause_o),
        .ex_tval_o        (ex_tval_o)
    );

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
// Testbench clock
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD = 50
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_mmu.sv
// MMU data path testbench
`default_nettype none
`include "mmu_settings.svh"

module tb_mmu import mmu_pkg::*; ();

    localparam int DRIVE_DELAY    = 10;
    localparam int WORDS          = 12;
    localparam int MAX_RECORDS    = 40;
    localparam int RESULT_TIMEOUT = 20;

    logic                 clk_i;
    logic                 rst_ni;
    logic                 req_i;
    logic [`MMU_XLEN-1:0] vaddr_i;
    logic                 is_store_i;
    logic [1:0]           priv_i;
    logic                 sum_i;
    logic                 en_translation_i;
    logic                 refill_i;
    logic [`MMU_VPNW-1:0] refill_vpn_i;
    logic [`MMU_PPNW-1:0] refill_ppn_i;
    logic [7:0]           refill_flags_i;
    logic [1:0]           refill_size_i;
    logic                 flush_i;
    logic                 hit_o;
    logic                 valid_o;
    logic                 miss_o;
    logic [`MMU_PLEN-1:0] paddr_o;
    logic                 ex_valid_o;
    logic [5:0]           ex_cause_o;
    logic [`MMU_XLEN-1:0] ex_tval_o;

    logic [63:0] golden [WORDS * MAX_RECORDS];
    int          pending_rec[$];
    int          pending_cycle[$];
    int          cycle_count = 0;
    int          checks = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    logic        timed_out = 1'b0;

    tb_clock #(.HALF_PERIOD(50)) u_clock (.clk_o(clk_i));

    mmu_data_top UUT (
        .clk_i(clk_i), .rst_ni(rst_ni), .req_i(req_i), .vaddr_i(vaddr_i),
        .is_store_i(is_store_i), .priv_i(priv_i), .sum_i(sum_i),
        .en_translation_i(en_translation_i), .refill_i(refill_i),
        .refill_vpn_i(refill_vpn_i), .refill_ppn_i(refill_ppn_i),
        .refill_flags_i(refill_flags_i), .refill_size_i(refill_size_i),
        .flush_i(flush_i), .hit_o(hit_o), .valid_o(valid_o), .miss_o(miss_o),
        .paddr_o(paddr_o), .ex_valid_o(ex_valid_o), .ex_cause_o(ex_cause_o),
        .ex_tval_o(ex_tval_o)
    );

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic logic [63:0] golden_word(input int rec, input int col);
        return golden[rec * WORDS + col];
    endfunction

    function automatic string lookup_name(input int rec);
        logic [63:0] va;
        sv39_vaddr_u view;
        va   = golden_word(rec, 1);
        view = va[`MMU_VLEN-1:0];
        return $sformatf("op%0d va %h (vpn %h.%h.%h)", rec, va,
                         view.f.vpn2, view.f.vpn1, view.f.vpn0);
    endfunction

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic check_paddr(input string name, input logic [`MMU_PLEN-1:0] exp,
                               input logic [`MMU_PLEN-1:0] act);
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_tval(input string name, input logic [`MMU_XLEN-1:0] exp,
                              input logic [`MMU_XLEN-1:0] act);
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_cause(input string name, input logic [5:0] exp, input logic [5:0] act);
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("Fail %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_result(input int rec);
        logic [63:0] w_miss;
        logic [63:0] w_exv;
        logic [63:0] w_cause;
        logic [63:0] w_paddr;
        string       name;
        name    = lookup_name(rec);
        w_miss  = golden_word(rec, 7);
        w_exv   = golden_word(rec, 8);
        w_cause = golden_word(rec, 9);
        w_paddr = golden_word(rec, 11);
        check_flag({name, " miss_o"}, w_miss[0], miss_o);
        check_flag({name, " ex_valid_o"}, w_exv[0], ex_valid_o);
        check_cause({name, " ex_cause_o"}, w_cause[5:0], ex_cause_o);
        check_tval({name, " ex_tval_o"}, golden_word(rec, 10), ex_tval_o);
        check_paddr({name, " paddr_o"}, w_paddr[`MMU_PLEN-1:0], paddr_o);
    endtask

    // results must show up exactly one cycle after their request
    always @(negedge clk_i) begin
        int rec;
        int issued;
        if (valid_o) begin
            if (pending_rec.size() == 0) begin
                other_errors++;
                $display("valid_o went high with no request outstanding, cycle %0d",
                         cycle_count);
            end else begin
                rec    = pending_rec.pop_front();
                issued = pending_cycle.pop_front();
                if (cycle_count != issued + 1) begin
                    other_errors++;
                    $display("result of op%0d came %0d cycles after its request",
                             rec, cycle_count - issued);
                end
                check_result(rec);
            end
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic clear_strobes();
        req_i    = 1'b0;
        refill_i = 1'b0;
        flush_i  = 1'b0;
    endtask

    task automatic drive_idle();
        @(posedge clk_i);
        #DRIVE_DELAY;
        clear_strobes();
    endtask

    task automatic apply_refill(input int rec);
        logic [63:0] w_vpn;
        logic [63:0] w_ppn;
        logic [63:0] w_flags;
        logic [63:0] w_size;
        w_vpn   = golden_word(rec, 1);
        w_ppn   = golden_word(rec, 2);
        w_flags = golden_word(rec, 3);
        w_size  = golden_word(rec, 4);
        @(posedge clk_i);
        #DRIVE_DELAY;
        clear_strobes();
        refill_i       = 1'b1;
        refill_vpn_i   = w_vpn[`MMU_VPNW-1:0];
        refill_ppn_i   = w_ppn[`MMU_PPNW-1:0];
        refill_flags_i = w_flags[7:0];
        refill_size_i  = w_size[1:0];
    endtask

    task automatic apply_flush();
        @(posedge clk_i);
        #DRIVE_DELAY;
        clear_strobes();
        flush_i = 1'b1;
    endtask

    // hit_o is combinational, so it is checked within the request cycle
    task automatic issue_lookup(input int rec);
        logic [63:0] w_store;
        logic [63:0] w_priv;
        logic [63:0] w_sum;
        logic [63:0] w_en;
        logic [63:0] w_hit;
        w_store = golden_word(rec, 2);
        w_priv  = golden_word(rec, 3);
        w_sum   = golden_word(rec, 4);
        w_en    = golden_word(rec, 5);
        w_hit   = golden_word(rec, 6);
        @(posedge clk_i);
        #DRIVE_DELAY;
        clear_strobes();
        req_i            = 1'b1;
        vaddr_i          = golden_word(rec, 1);
        is_store_i       = w_store[0];
        priv_i           = w_priv[1:0];
        sum_i            = w_sum[0];
        en_translation_i = w_en[0];
        pending_rec.push_back(rec);
        pending_cycle.push_back(cycle_count);
        @(negedge clk_i);
        check_flag({lookup_name(rec), " hit_o"}, w_hit[0], hit_o);
    endtask

    task automatic wait_results(input string what);
        int waited;
        waited = 0;
        while (pending_rec.size() != 0 && waited < RESULT_TIMEOUT) begin
            @(posedge clk_i);
            waited++;
        end
        if (pending_rec.size() != 0) begin
            other_errors++;
            timed_out = 1'b1;
            $display("no valid_o for %s within %0d cycles", what, RESULT_TIMEOUT);
        end
    endtask

    initial begin
        int          rec;
        logic        stop;
        logic [63:0] op;
        rst_ni           = 1'b0;
        req_i            = 1'b0;
        vaddr_i          = '0;
        is_store_i       = 1'b0;
        priv_i           = `MMU_PRIV_S;
        sum_i            = 1'b0;
        en_translation_i = 1'b0;
        refill_i         = 1'b0;
        refill_vpn_i     = '0;
        refill_ppn_i     = '0;
        refill_flags_i   = '0;
        refill_size_i    = '0;
        flush_i          = 1'b0;
        $readmemh("bench/mmu_golden.txt", golden);
        repeat (3) @(posedge clk_i);
        check_flag("reset valid_o", 1'b0, valid_o);
        check_flag("reset miss_o", 1'b0, miss_o);
        check_flag("reset ex_valid_o", 1'b0, ex_valid_o);
        #DRIVE_DELAY;
        rst_ni = 1'b1;

        rec  = 0;
        stop = 1'b0;
        while (!stop && !timed_out && rec < MAX_RECORDS) begin
            op = golden_word(rec, 0);
            if ($isunknown(op) || op == 0) begin
                stop = 1'b1;
            end else begin
                case (op)
                    1: apply_refill(rec);
                    2: apply_flush();
                    3: begin
                        issue_lookup(rec);
                        drive_idle();
                        wait_results(lookup_name(rec));
                    end
                    // next operation goes out on the following cycle
                    4: issue_lookup(rec);
                    default: begin
                        other_errors++;
                        $display("unknown operation %0d in golden record %0d", op, rec);
                        stop = 1'b1;
                    end
                endcase
                rec++;
            end
        end
        if (!timed_out) begin
            drive_idle();
            wait_results("the last lookup");
        end
        if (rec == 0) begin
            other_errors++;
            $display("golden file is missing or holds no operations");
        end

        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/mmu_golden.txt
// op 1 refill: vpn ppn flags size, op 2 flush, op 0 ends the list; every row has 12 words
// op 3 lookup, op 4 lookup with next op at once: vaddr st priv sum en hit miss exv cause tval paddr
3 123456789A        0 1 0 0 1 0 0 00 0                123456789A
3 8000000000001000  1 0 0 0 1 0 0 00 0                1000
3 5555000           0 1 0 1 0 1 0 00 0                0
1 40403 12345 CF 0 0 0 0 0 0 0 0
1 80A00 ABC00 DF 1 0 0 0 0 0 0 0
1 C0000 40000 C3 2 0 0 0 0 0 0 0
4 40403ABC          0 1 0 1 1 0 0 00 0                12345ABC
4 40403010          1 1 0 1 1 0 0 00 0                12345010
4 80BA3456          0 0 0 1 1 0 0 00 0                ABDA3456
3 D57CD123          0 1 0 1 1 0 0 00 0                557CD123
3 5555000           0 1 0 1 0 1 0 00 0                0
3 40403ABC          0 0 0 1 1 0 1 0D 40403ABC         0
3 80BA3456          0 1 0 1 1 0 1 0D 80BA3456         0
3 80BA3456          0 1 1 1 1 0 0 00 0                ABDA3456
3 D57CD123          1 1 0 1 1 0 1 0F D57CD123         0
1 10 777 47 0 0 0 0 0 0 0 0
3 10200             1 1 0 1 1 0 1 0F 10200            0
3 10200             0 1 0 1 1 0 0 00 0                777200
3 4000000000        0 1 0 1 0 0 1 05 4000000000       0
3 FFFFFF0000000000  1 1 0 1 0 0 1 07 FFFFFF0000000000 0
1 20 999 CF 0 0 0 0 0 0 0 0
3 40403ABC          0 1 0 1 0 1 0 00 0                0
3 20123             0 1 0 1 1 0 0 00 0                999123
1 80A00 55400 DF 1 0 0 0 0 0 0 0
3 80BA3456          0 0 0 1 1 0 0 00 0                555A3456
2 0 0 0 0 0 0 0 0 0 0 0
3 80BA3456          0 0 0 1 0 1 0 00 0                0
3 D57CD123          0 1 0 1 0 1 0 00 0                0
0 0 0 0 0 0 0 0 0 0 0 0

//--- list.f
+incdir+common
common/mmu_pkg.sv
dtlb/dtlb.sv
design/perm_check.sv
design/xlate_result.sv
design/mmu_data_top.sv
bench/tb_clock.sv
bench/tb_mmu.sv

//--- run_sim.sh
#!/bin/sh
# build and run the MMU testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_mmu -f list.f -o sim_mmu \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_mmu > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log

grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || { echo "no result line in sim.log"; exit 1; }
exit 0
